/* verilog/lsu_cfg_pkg.sv */
/*
 * size constants for the load/store forwarding datapath:
 * address and data widths, byte lanes, the two-word window
 * and the address bits used by the word and doubleword compares
 */

package lsu_cfg_pkg;

   // **************************************************
   // widths
   // **************************************************
   localparam int ADDR_W         = 32;   // byte address
   localparam int DATA_W         = 32;   // one data word
   localparam int BYTE_W         = 8;
   localparam int BYTES_PER_WORD = DATA_W / BYTE_W;
   localparam int WIN_W          = 2 * DATA_W;   // lo word plus hi word

   // **************************************************
   // compare positions
   // **************************************************
   localparam int WORD_LSB       = 2;    // addr[31:2] picks a word
   localparam int DWORD_LSB      = 3;    // addr[31:3] picks a doubleword

   // store stages searched by a dc2 load (dc3, dc4, dc5)
   localparam int FWD_STAGES     = 3;

endpackage

/* verilog/lsu_types_pkg.sv */
/*
 * access size encoding and the per-stage request entry
 * carried down the dc2..dc5 pipeline
 */

package lsu_types_pkg;

   // size of a load or store access
   typedef enum logic [1:0] {
      SZ_BYTE = 2'b00,
      SZ_HALF = 2'b01,
      SZ_WORD = 2'b10
   } access_size_e;

   // **************************************************
   // one request as held in a pipeline stage
   // **************************************************
   // lo_* belongs to word addr[31:2], hi_* to end_addr[31:2].
   // hi_byteen is only nonzero when the access crosses a word
   typedef struct packed {
      logic                                   valid;
      logic                                   load;         // 0 means store
      logic                                   side_effect;  // io access without full hit
      logic [lsu_cfg_pkg::ADDR_W-1:0]         addr;
      logic [lsu_cfg_pkg::ADDR_W-1:0]         end_addr;     // last byte touched
      logic                                   dual;         // spans two words
      logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] lo_byteen;
      logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] hi_byteen;
      logic [lsu_cfg_pkg::DATA_W-1:0]         lo_data;
      logic [lsu_cfg_pkg::DATA_W-1:0]         hi_data;
   } stage_entry_t;

endpackage

/* verilog/lsu_stage_if.sv */
/*
 * one pipeline stage entry, driven by the stage pipe
 * and read by the forwarding and coalescing blocks
 */

interface lsu_stage_if (
   input logic clk,
   input logic rst_n
);
   import lsu_types_pkg::*;

   stage_entry_t entry;   // valid is a one cycle level per stage

   // producer side
   modport src (
      output entry
   );

   // consumers get clock and reset for their checks
   modport dst (
      input clk,
      input rst_n,
      input entry
   );

endinterface

/* verilog/lsu_stage_pipe.sv */
/*
 * dc1 request decode (end address, dual flag, byte enables,
 * two-word data window) and the dc2..dc5 stage registers
 */

module lsu_stage_pipe (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           req_valid,
   input  logic                           req_load,
   input  logic                           req_side_effect,
   input  lsu_types_pkg::access_size_e    req_size,
   input  logic [lsu_cfg_pkg::ADDR_W-1:0] req_addr,
   input  logic [lsu_cfg_pkg::DATA_W-1:0] req_store_data,
   lsu_stage_if.src                       dc2,
   lsu_stage_if.src                       dc3,
   lsu_stage_if.src                       dc4,
   lsu_stage_if.src                       dc5
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   stage_entry_t                  dc1_entry;
   stage_entry_t                  dc2_q;
   stage_entry_t                  dc3_q;
   stage_entry_t                  dc4_q;
   stage_entry_t                  dc5_q;

   logic [BYTES_PER_WORD-1:0]     base_byteen;
   logic [ADDR_W-1:0]             size_m1;        // access size in bytes minus one
   logic [ADDR_W-1:0]             end_addr_dc1;
   logic [2*BYTES_PER_WORD-1:0]   byteen_win;
   logic [WIN_W-1:0]              data_win;

   // **************************************************
   // dc1 decode
   // **************************************************
   always_comb begin
      case (req_size)
         SZ_BYTE: begin
            base_byteen = 4'b0001;
            size_m1     = '0;
         end
         SZ_HALF: begin
            base_byteen = 4'b0011;
            size_m1     = ADDR_W'(1);
         end
         default: begin                 // word and the unused code
            base_byteen = 4'b1111;
            size_m1     = ADDR_W'(3);
         end
      endcase
   end

   assign end_addr_dc1 = req_addr + size_m1;

   // place enables and data at their byte offset in the two-word window
   assign byteen_win = {{BYTES_PER_WORD{1'b0}}, base_byteen} << req_addr[WORD_LSB-1:0];
   assign data_win   = {{DATA_W{1'b0}}, req_store_data} << (BYTE_W * req_addr[WORD_LSB-1:0]);

   always_comb begin
      dc1_entry.valid       = req_valid;
      dc1_entry.load        = req_load;
      dc1_entry.side_effect = req_side_effect;
      dc1_entry.addr        = req_addr;
      dc1_entry.end_addr    = end_addr_dc1;
      dc1_entry.dual        = (req_addr[WORD_LSB] != end_addr_dc1[WORD_LSB]);
      dc1_entry.lo_byteen   = byteen_win[BYTES_PER_WORD-1:0];
      dc1_entry.hi_byteen   = byteen_win[2*BYTES_PER_WORD-1:BYTES_PER_WORD];
      dc1_entry.lo_data     = data_win[DATA_W-1:0];
      dc1_entry.hi_data     = data_win[WIN_W-1:DATA_W];
   end

   // **************************************************
   // stage registers without stall
   // **************************************************
   always_ff @(posedge clk) begin
      dc2_q <= dc1_entry;
      dc3_q <= dc2_q;
      dc4_q <= dc3_q;
      dc5_q <= dc4_q;
      if (!rst_n) begin              // empty pipeline
         dc2_q.valid <= 1'b0;
         dc3_q.valid <= 1'b0;
         dc4_q.valid <= 1'b0;
         dc5_q.valid <= 1'b0;
      end
   end

   assign dc2.entry = dc2_q;
   assign dc3.entry = dc3_q;
   assign dc4.entry = dc4_q;
   assign dc5.entry = dc5_q;

   // a byte access can never cross a word
   a_byte_not_dual: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid && req_size == SZ_BYTE) |=> (dc2_q.valid && !dc2_q.dual));

endmodule

/* verilog/lsu_fwd_select.sv */
/*
 * store to load forwarding for one half of the dc2 load window:
 * byte hit detection against the stores in dc3, dc4 and dc5,
 * youngest store wins per byte
 */

module lsu_fwd_select #(
   parameter bit HI = 1'b0             // 0 checks the lo load window, 1 the hi window
) (
   lsu_stage_if.dst                           dc2,
   lsu_stage_if.dst                           dc3,
   lsu_stage_if.dst                           dc4,
   lsu_stage_if.dst                           dc5,
   output logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] byte_hit,
   output logic [lsu_cfg_pkg::DATA_W-1:0]         fwd_data
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   stage_entry_t                  st [FWD_STAGES];    // index 0 is the youngest
   logic [ADDR_W-1:WORD_LSB]      ld_word;
   logic [BYTES_PER_WORD-1:0]     ld_byteen;
   logic [FWD_STAGES-1:0]         st_ok;
   logic [FWD_STAGES-1:0]         match_lo;
   logic [FWD_STAGES-1:0]         match_hi;
   logic [BYTES_PER_WORD-1:0]     hit_lo [FWD_STAGES];
   logic [BYTES_PER_WORD-1:0]     hit_hi [FWD_STAGES];

   assign st[0] = dc3.entry;
   assign st[1] = dc4.entry;
   assign st[2] = dc5.entry;

   // load half under test
   assign ld_word   = HI ? dc2.entry.end_addr[ADDR_W-1:WORD_LSB]
                         : dc2.entry.addr[ADDR_W-1:WORD_LSB];
   assign ld_byteen = HI ? dc2.entry.hi_byteen : dc2.entry.lo_byteen;

   // **************************************************
   // word address compare and byte hits
   // **************************************************
   for (genvar s = 0; s < FWD_STAGES; s++) begin : g_stage
      assign st_ok[s]    = st[s].valid & ~st[s].load & dc2.entry.valid;
      assign match_lo[s] = st_ok[s] & (ld_word == st[s].addr[ADDR_W-1:WORD_LSB]);
      assign match_hi[s] = st_ok[s] & (ld_word == st[s].end_addr[ADDR_W-1:WORD_LSB]);

      // a store's lo and hi windows never share a lane for the same word
      assign hit_lo[s] = {BYTES_PER_WORD{match_lo[s]}} & st[s].lo_byteen & ld_byteen;
      assign hit_hi[s] = {BYTES_PER_WORD{match_hi[s]}} & st[s].hi_byteen & ld_byteen;
   end

   // **************************************************
   // byte select from oldest to youngest store
   // **************************************************
   always_comb begin
      byte_hit = '0;
      fwd_data = '0;                   // no hit forwards zero
      for (int s = FWD_STAGES - 1; s >= 0; s--) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (hit_lo[s][b]) begin
               fwd_data[b*BYTE_W +: BYTE_W] = st[s].lo_data[b*BYTE_W +: BYTE_W];
            end else if (hit_hi[s][b]) begin
               fwd_data[b*BYTE_W +: BYTE_W] = st[s].hi_data[b*BYTE_W +: BYTE_W];
            end
         end
         byte_hit = byte_hit | hit_lo[s] | hit_hi[s];
      end
   end

endmodule

/* verilog/lsu_fwd_merge.sv */
/*
 * joins the lo and hi forwarding halves, full hit decision,
 * load data alignment, dc3 registers and the final bus/forward mux
 */

module lsu_fwd_merge (
   input  logic                                   clk,
   input  logic                                   rst_n,
   lsu_stage_if.dst                               dc2,
   input  logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] lo_byte_hit,
   input  logic [lsu_cfg_pkg::BYTES_PER_WORD-1:0] hi_byte_hit,
   input  logic [lsu_cfg_pkg::DATA_W-1:0]         lo_fwd_data,
   input  logic [lsu_cfg_pkg::DATA_W-1:0]         hi_fwd_data,
   input  logic [lsu_cfg_pkg::DATA_W-1:0]         ld_bus_data_dc3,
   output logic                                   ld_full_hit_dc3,
   output logic [lsu_cfg_pkg::DATA_W-1:0]         bus_read_data_dc3
);
   import lsu_cfg_pkg::*;

   logic                 full_hit_lo;
   logic                 full_hit_hi;
   logic                 ld_full_hit_dc2;
   logic [WIN_W-1:0]     fwd_win;
   logic [DATA_W-1:0]    ld_fwd_data_dc2;
   logic [DATA_W-1:0]    ld_fwd_data_dc3;

   // **************************************************
   // full hit in dc2
   // **************************************************
   // every enabled load byte must be covered by some store
   assign full_hit_lo = &(lo_byte_hit | ~dc2.entry.lo_byteen);
   assign full_hit_hi = &(hi_byte_hit | ~dc2.entry.hi_byteen);

   assign ld_full_hit_dc2 = full_hit_lo & full_hit_hi &
                            dc2.entry.valid & dc2.entry.load & ~dc2.entry.side_effect;

   // move the load's first byte down to lane 0
   assign fwd_win         = {hi_fwd_data, lo_fwd_data};
   assign ld_fwd_data_dc2 = DATA_W'(fwd_win >> (BYTE_W * dc2.entry.addr[WORD_LSB-1:0]));

   // **************************************************
   // dc3
   // **************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_full_hit_dc3 <= 1'b0;
      end else begin
         ld_full_hit_dc3 <= ld_full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      ld_fwd_data_dc3 <= ld_fwd_data_dc2;
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? ld_fwd_data_dc3 : ld_bus_data_dc3;

   // a forwarded result needs a plain load in dc2 the cycle before
   a_full_hit_src: assert property (@(posedge clk) disable iff (!rst_n)
      ld_full_hit_dc3 |->
         $past(dc2.entry.valid && dc2.entry.load && !dc2.entry.side_effect));

endmodule

/* verilog/lsu_coalesce_check.sv */
/*
 * write coalescing check for the dc5 request against the
 * nearest younger valid request in dc4, dc3 or dc2
 */

module lsu_coalesce_check (
   lsu_stage_if.dst dc2,
   lsu_stage_if.dst dc3,
   lsu_stage_if.dst dc4,
   lsu_stage_if.dst dc5,
   output logic     no_word_merge_dc5,
   output logic     no_dword_merge_dc5
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   stage_entry_t    yng;          // nearest younger entry
   logic            yng_valid;
   logic            chk_dc5;
   logic            word_diff;
   logic            dword_diff;

   // **************************************************
   // pick the nearest younger request
   // **************************************************
   always_comb begin
      if (dc4.entry.valid) begin
         yng = dc4.entry;
      end else if (dc3.entry.valid) begin
         yng = dc3.entry;
      end else begin
         yng = dc2.entry;            // only looked at when dc2 is valid
      end
   end

   assign yng_valid = dc4.entry.valid | dc3.entry.valid | dc2.entry.valid;

   // dual dc5 requests are not checked
   assign chk_dc5    = dc5.entry.valid & ~dc5.entry.dual & yng_valid;

   assign word_diff  = (dc5.entry.addr[ADDR_W-1:WORD_LSB]  != yng.addr[ADDR_W-1:WORD_LSB]);
   assign dword_diff = (dc5.entry.addr[ADDR_W-1:DWORD_LSB] != yng.addr[ADDR_W-1:DWORD_LSB]);

   // a younger load also blocks the merge
   assign no_word_merge_dc5  = chk_dc5 & (yng.load | word_diff);
   assign no_dword_merge_dc5 = chk_dc5 & (yng.load | dword_diff);

   // doubleword blocked means word blocked too
   a_dword_word: assert property (@(posedge dc5.clk) disable iff (!dc5.rst_n)
      no_dword_merge_dc5 |-> no_word_merge_dc5);

endmodule

/* verilog/lsu_fwd_top.sv */
/*
 * top level of the load/store forwarding and coalescing check:
 * stage pipe, lo/hi forward selectors, merge and coalesce check
 */

module lsu_fwd_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           req_valid,
   input  logic                           req_load,
   input  logic                           req_side_effect,
   input  lsu_types_pkg::access_size_e    req_size,
   input  logic [lsu_cfg_pkg::ADDR_W-1:0] req_addr,
   input  logic [lsu_cfg_pkg::DATA_W-1:0] req_store_data,
   input  logic [lsu_cfg_pkg::DATA_W-1:0] ld_bus_data_dc3,   // bus return data
   output logic                           ld_full_hit_dc3,
   output logic [lsu_cfg_pkg::DATA_W-1:0] bus_read_data_dc3,
   output logic                           no_word_merge_dc5,
   output logic                           no_dword_merge_dc5
);
   import lsu_cfg_pkg::*;

   logic [BYTES_PER_WORD-1:0] lo_byte_hit;
   logic [BYTES_PER_WORD-1:0] hi_byte_hit;
   logic [DATA_W-1:0]         lo_fwd_data;
   logic [DATA_W-1:0]         hi_fwd_data;

   // **************************************************
   // stage entries
   // **************************************************
   lsu_stage_if dc2_if (.clk(clk), .rst_n(rst_n));
   lsu_stage_if dc3_if (.clk(clk), .rst_n(rst_n));
   lsu_stage_if dc4_if (.clk(clk), .rst_n(rst_n));
   lsu_stage_if dc5_if (.clk(clk), .rst_n(rst_n));

   lsu_stage_pipe u_pipe (
      .clk             (clk),
      .rst_n           (rst_n),
      .req_valid       (req_valid),
      .req_load        (req_load),
      .req_side_effect (req_side_effect),
      .req_size        (req_size),
      .req_addr        (req_addr),
      .req_store_data  (req_store_data),
      .dc2             (dc2_if),
      .dc3             (dc3_if),
      .dc4             (dc4_if),
      .dc5             (dc5_if)
   );

   // **************************************************
   // forwarding
   // **************************************************
   lsu_fwd_select #(.HI(1'b0)) u_fwd_lo (
      .dc2      (dc2_if),
      .dc3      (dc3_if),
      .dc4      (dc4_if),
      .dc5      (dc5_if),
      .byte_hit (lo_byte_hit),
      .fwd_data (lo_fwd_data)
   );

   lsu_fwd_select #(.HI(1'b1)) u_fwd_hi (
      .dc2      (dc2_if),
      .dc3      (dc3_if),
      .dc4      (dc4_if),
      .dc5      (dc5_if),
      .byte_hit (hi_byte_hit),
      .fwd_data (hi_fwd_data)
   );

   lsu_fwd_merge u_merge (
      .clk               (clk),
      .rst_n             (rst_n),
      .dc2               (dc2_if),
      .lo_byte_hit       (lo_byte_hit),
      .hi_byte_hit       (hi_byte_hit),
      .lo_fwd_data       (lo_fwd_data),
      .hi_fwd_data       (hi_fwd_data),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3)
   );

   lsu_coalesce_check u_coalesce (
      .dc2                (dc2_if),
      .dc3                (dc3_if),
      .dc4                (dc4_if),
      .dc5                (dc5_if),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5)
   );

endmodule

/* sim/tb_clk_gen.sv */
/*
 * testbench clock and synchronous active low reset,
 * reset held for the first RST_CYCLES rising edges
 */

module tb_clk_gen #(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 2
) (
   output logic clk,
   output logic rst_n
);
   logic rst_q   = 1'b0;
   int   rst_cnt = 0;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // released on a rising edge so the falling edge sees a stable level
   always @(posedge clk) begin
      if (rst_cnt < RST_CYCLES - 1) begin
         rst_cnt <= rst_cnt + 1;
      end else begin
         rst_q <= 1'b1;
      end
   end

   assign rst_n = rst_q;

endmodule

/* sim/tb_checker.sv */
/*
 * reference model and compare for the forwarding testbench:
 * four stage request model (dc2..dc5), predicted full hit,
 * dc3 read data and dc5 merge flags, checked at every falling edge
 */

module tb_checker (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           req_valid,
   input  logic                           req_load,
   input  logic                           req_side_effect,
   input  lsu_types_pkg::access_size_e    req_size,
   input  logic [lsu_cfg_pkg::ADDR_W-1:0] req_addr,
   input  logic [lsu_cfg_pkg::DATA_W-1:0] req_store_data,
   input  logic [lsu_cfg_pkg::DATA_W-1:0] ld_bus_data_dc3,
   input  logic                           ld_full_hit_dc3,
   input  logic [lsu_cfg_pkg::DATA_W-1:0] bus_read_data_dc3,
   input  logic                           no_word_merge_dc5,
   input  logic                           no_dword_merge_dc5,
   output int                             error_count,
   output int                             hit_count
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   // request model from dc2 at index 0 to dc5 at index 3
   logic              m_valid [4];
   logic              m_load  [4];
   logic              m_se    [4];
   logic [ADDR_W-1:0] m_addr  [4];
   int                m_len   [4];      // bytes touched
   logic [DATA_W-1:0] m_data  [4];      // store data as presented and unshifted

   logic              exp_hit;         // expected ld_full_hit_dc3
   logic [DATA_W-1:0] exp_fwd;
   logic              nxt_hit;
   logic [DATA_W-1:0] nxt_fwd;
   logic              exp_nw;
   logic              exp_nd;
   logic              armed;           // model in step once reset was seen

   function automatic int size_bytes(access_size_e sz);
      case (sz)
         SZ_BYTE: return 1;
         SZ_HALF: return 2;
         default: return 4;
      endcase
   endfunction

   // store in stage s writes byte address b
   function automatic logic covers(int s, logic [ADDR_W-1:0] b);
      return m_valid[s] && !m_load[s] && (b >= m_addr[s]) &&
             (b < m_addr[s] + ADDR_W'(m_len[s]));
   endfunction

   // **************************************************
   // forwarding byte by byte over the load's addresses
   // **************************************************
   task automatic predict_fwd(output logic hit, output logic [DATA_W-1:0] data);
      logic [ADDR_W-1:0] b;
      logic              got;
      hit  = m_valid[0] && m_load[0] && !m_se[0];
      data = '0;
      for (int i = 0; i < m_len[0]; i++) begin
         b   = m_addr[0] + ADDR_W'(i);
         got = 1'b0;
         for (int s = 1; s < 4 && !got; s++) begin   // dc3 is the youngest store
            if (covers(s, b)) begin
               data[8*i +: 8] = m_data[s][8*(b - m_addr[s]) +: 8];
               got            = 1'b1;
            end
         end
         if (!got) begin
            hit = 1'b0;
         end
      end
   endtask

   // nearest younger valid request decides the dc5 merge
   task automatic predict_merge(output logic nw, output logic nd);
      logic [ADDR_W-1:0] last;
      int                y;
      last = m_addr[3] + ADDR_W'(m_len[3] - 1);
      y    = -1;
      nw   = 1'b0;
      nd   = 1'b0;
      for (int s = 2; s >= 0; s--) begin
         if (y < 0 && m_valid[s]) begin
            y = s;
         end
      end
      if (m_valid[3] && (m_addr[3][2] == last[2]) && y >= 0) begin
         nw = m_load[y] || (m_addr[y][ADDR_W-1:2] != m_addr[3][ADDR_W-1:2]);
         nd = m_load[y] || (m_addr[y][ADDR_W-1:3] != m_addr[3][ADDR_W-1:3]);
      end
   endtask

   task automatic check_value(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
      if (exp !== act) begin
         error_count++;
         $display("ERROR %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
      end
   endtask

   // **************************************************
   // compare and then step the model to the next edge
   // **************************************************
   initial begin
      error_count = 0;
      hit_count   = 0;
      armed       = 1'b0;
      exp_hit     = 1'b0;
      exp_fwd     = '0;
      for (int s = 0; s < 4; s++) begin
         m_valid[s] = 1'b0;
         m_len[s]   = 0;
      end
      forever begin
         @(negedge clk);
         if (armed) begin
            predict_merge(exp_nw, exp_nd);
            check_value("ld_full_hit_dc3", DATA_W'(exp_hit), DATA_W'(ld_full_hit_dc3));
            check_value("bus_read_data_dc3", exp_hit ? exp_fwd : ld_bus_data_dc3,
                        bus_read_data_dc3);
            check_value("no_word_merge_dc5", DATA_W'(exp_nw), DATA_W'(no_word_merge_dc5));
            check_value("no_dword_merge_dc5", DATA_W'(exp_nd), DATA_W'(no_dword_merge_dc5));
            if (exp_hit) begin
               hit_count++;
            end
         end
         predict_fwd(nxt_hit, nxt_fwd);   // lands in dc3 at the coming edge
         for (int s = 3; s > 0; s--) begin
            m_valid[s] = m_valid[s-1];
            m_load[s]  = m_load[s-1];
            m_se[s]    = m_se[s-1];
            m_addr[s]  = m_addr[s-1];
            m_len[s]   = m_len[s-1];
            m_data[s]  = m_data[s-1];
         end
         m_valid[0] = req_valid;
         m_load[0]  = req_load;
         m_se[0]    = req_side_effect;
         m_addr[0]  = req_addr;
         m_len[0]   = size_bytes(req_size);
         m_data[0]  = req_store_data;
         exp_hit    = nxt_hit;
         exp_fwd    = nxt_fwd;
         if (!rst_n) begin
            for (int s = 0; s < 4; s++) begin
               m_valid[s] = 1'b0;
            end
            exp_hit = 1'b0;
            armed   = 1'b1;
         end
      end
   end

endmodule

/* sim/tb_lsu_fwd.sv */
/*
 * testbench top for the forwarding and coalescing check:
 * seeded random requests in one 32 byte region, random bus data,
 * cycle limit and the closing report
 */

module tb_lsu_fwd;
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   localparam int                NUM_REQ    = 2000;
   localparam int                DRAIN      = 6;              // empty cycles to flush dc5
   localparam int                MAX_CYCLES = NUM_REQ + 100;
   localparam logic [ADDR_W-1:0] REGION     = 32'h0000_4000;  // 32 byte aligned

   logic              clk;
   logic              rst_n;
   logic              req_valid       = 1'b0;
   logic              req_load        = 1'b0;
   logic              req_side_effect = 1'b0;
   access_size_e      req_size        = SZ_BYTE;
   logic [ADDR_W-1:0] req_addr        = '0;
   logic [DATA_W-1:0] req_store_data  = '0;
   logic [DATA_W-1:0] ld_bus_data_dc3 = '0;
   logic              ld_full_hit_dc3;
   logic [DATA_W-1:0] bus_read_data_dc3;
   logic              no_word_merge_dc5;
   logic              no_dword_merge_dc5;

   int                seed      = 85;
   int                req_cnt   = 0;
   int                drain_cnt = 0;
   int                cycle_cnt;
   int                error_count;
   int                hit_count;
   int                sz_sel;
   logic [31:0]       r;
   logic              done      = 1'b0;

   tb_clk_gen #(.PERIOD(40), .RST_CYCLES(2)) u_clk (.clk(clk), .rst_n(rst_n));

   lsu_fwd_top UUT (
      .clk                (clk),
      .rst_n              (rst_n),
      .req_valid          (req_valid),
      .req_load           (req_load),
      .req_side_effect    (req_side_effect),
      .req_size           (req_size),
      .req_addr           (req_addr),
      .req_store_data     (req_store_data),
      .ld_bus_data_dc3    (ld_bus_data_dc3),
      .ld_full_hit_dc3    (ld_full_hit_dc3),
      .bus_read_data_dc3  (bus_read_data_dc3),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5)
   );

   tb_checker u_checker (
      .clk                (clk),
      .rst_n              (rst_n),
      .req_valid          (req_valid),
      .req_load           (req_load),
      .req_side_effect    (req_side_effect),
      .req_size           (req_size),
      .req_addr           (req_addr),
      .req_store_data     (req_store_data),
      .ld_bus_data_dc3    (ld_bus_data_dc3),
      .ld_full_hit_dc3    (ld_full_hit_dc3),
      .bus_read_data_dc3  (bus_read_data_dc3),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5),
      .error_count        (error_count),
      .hit_count          (hit_count)
   );

   // **************************************************
   // stimulus
   // **************************************************
   always @(posedge clk) begin
      ld_bus_data_dc3 <= $random(seed);            // new bus return data every cycle
      if (rst_n && req_cnt < NUM_REQ) begin
         r      = $random(seed);
         sz_sel = $unsigned($random(seed)) % 3;
         req_valid       <= (r[2:0] != 3'd0);      // about 7 in 8
         req_load        <= r[3];
         req_side_effect <= (r[6:4] == 3'd0);      // about 1 in 8
         req_addr        <= REGION | ADDR_W'(r[12:8]);
         req_store_data  <= $random(seed);
         case (sz_sel)
            0:       req_size <= SZ_BYTE;
            1:       req_size <= SZ_HALF;
            default: req_size <= SZ_WORD;
         endcase
         req_cnt++;
      end else if (rst_n) begin
         req_valid <= 1'b0;
         if (drain_cnt == DRAIN) begin
            done = 1'b1;
         end else begin
            drain_cnt++;
         end
      end
   end

   // cycle limit
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: the run was still going after %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
   end

   // **************************************************
   // closing report
   // **************************************************
   initial begin
      wait (done);
      repeat (2) @(posedge clk);                    // last falling edge compare is done
      $display("errors: %0d, full hits checked: %0d", error_count, hit_count);
      if (hit_count == 0) begin
         $display("no load was ever fully forwarded, forwarding went unchecked");
      end
      if (error_count == 0 && hit_count > 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* all.f */
verilog/lsu_cfg_pkg.sv
verilog/lsu_types_pkg.sv
verilog/lsu_stage_if.sv
verilog/lsu_stage_pipe.sv
verilog/lsu_fwd_select.sv
verilog/lsu_fwd_merge.sv
verilog/lsu_coalesce_check.sv
verilog/lsu_fwd_top.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/tb_lsu_fwd.sv

/* Makefile */
# Verilator build and run of the forwarding testbench

TOP = tb_lsu_fwd

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
